/* rtl/fix_seq_pkg.sv */
package fix_seq_pkg;

   // one BCD digit of the sequence counter
   parameter int DIGIT_W = 4;

   // a digit at this value rolls to zero and carries
   parameter logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9;

   // message type field inside tuser
   parameter int TYPE_LSB = 32;
   parameter int TYPE_W = 4;

   // message types carried in tuser
   // only application messages consume a sequence number
   typedef enum logic [TYPE_W-1:0] {
      FIX_MSG_NONE = 4'd0,
      FIX_MSG_SESSION = 4'd1,
      FIX_MSG_APP = 4'd2
   } fix_msg_type_e;

endpackage

/* rtl/bcd_seq_counter.sv */
`timescale 1ns/10ps

module bcd_seq_counter #(
   parameter int TUSER_WIDTH = 128,
   parameter int NUM_DIGITS = 8,
   parameter int OUT_DIGITS = 6
) (
   input  logic clk,
   input  logic reset,

   input  logic tvalid,
   input  logic tlast,
   input  logic [TUSER_WIDTH-1:0] tuser,

   input  logic resend_load,
   input  logic [NUM_DIGITS*fix_seq_pkg::DIGIT_W-1:0] resend_begin,

   output logic [OUT_DIGITS*fix_seq_pkg::DIGIT_W-1:0] seq_digits,
   output logic seq_wr,
   output logic resend_ack
);

   localparam int DW = fix_seq_pkg::DIGIT_W;

   logic [NUM_DIGITS-1:0][DW-1:0] count_q;
   logic [NUM_DIGITS-1:0][DW-1:0] count_inc;
   logic [NUM_DIGITS-1:0] carry;

   fix_seq_pkg::fix_msg_type_e msg_type;
   logic pkt_end;
   logic is_app;
   logic end_q;
   logic inc_q;

   // parameter sanity
   if (OUT_DIGITS > NUM_DIGITS) begin : g_bad_out_digits
      $error("bcd_seq_counter: OUT_DIGITS must not exceed NUM_DIGITS");
   end
   if (TUSER_WIDTH < fix_seq_pkg::TYPE_LSB + fix_seq_pkg::TYPE_W) begin : g_bad_tuser
      $error("bcd_seq_counter: tuser too narrow for the message type field");
   end

   // stream has no ready, so any valid last beat ends a packet
   assign pkt_end = tvalid && tlast;

   assign msg_type = fix_seq_pkg::fix_msg_type_e'(
      tuser[fix_seq_pkg::TYPE_LSB +: fix_seq_pkg::TYPE_W]);

   always_comb begin
      case (msg_type)
         fix_seq_pkg::FIX_MSG_APP: begin
            is_app = 1'b1;
         end
         fix_seq_pkg::FIX_MSG_SESSION, fix_seq_pkg::FIX_MSG_NONE: begin
            is_app = 1'b0;
         end
         default: begin
            is_app = 1'b0;
         end
      endcase
   end

   // stage one: registered end strobe and increment request
   // a load in the same cycle takes the place of the increment
   always_ff @(posedge clk) begin
      if (reset) begin
         end_q <= 1'b0;
         inc_q <= 1'b0;
      end
      else begin
         end_q <= pkt_end;
         inc_q <= pkt_end && is_app && !resend_load;
      end
   end

   // decimal +1 with full carry in one cycle
   for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
      if (i == 0) begin : g_lsd
         assign carry[i] = 1'b1;
      end
      else begin : g_upper
         assign carry[i] = carry[i-1] && (count_q[i-1] == fix_seq_pkg::DIGIT_MAX);
      end

      always_comb begin
         if (!carry[i]) begin
            count_inc[i] = count_q[i];
         end
         else if (count_q[i] == fix_seq_pkg::DIGIT_MAX) begin
            count_inc[i] = '0;
         end
         else begin
            count_inc[i] = count_q[i] + 1'b1;
         end
      end
   end

   // all nines wraps to zero through the carry chain
   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= '0;
         seq_wr <= 1'b0;
         resend_ack <= 1'b0;
      end
      else begin
         seq_wr <= end_q;
         if (resend_load) begin
            count_q <= resend_begin;
            resend_ack <= 1'b1;
         end
         else if (inc_q) begin
            count_q <= count_inc;
         end
      end
   end

   // fifo sees the value after this packet's update
   assign seq_digits = count_q[OUT_DIGITS-1:0];

   function automatic logic all_bcd(input logic [NUM_DIGITS*DW-1:0] value);
      logic ok;
      ok = 1'b1;
      for (int d = 0; d < NUM_DIGITS; d++) begin
         if (value[d*DW +: DW] > fix_seq_pkg::DIGIT_MAX) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   // every write traces back to a sampled packet end two edges earlier
   a_wr_from_end: assert property (
      @(posedge clk) disable iff (reset)
      seq_wr |-> $past(pkt_end, 2)
   ) else $error("bcd_seq_counter: write strobe without a packet end");

   a_resend_bcd: assert property (
      @(posedge clk) disable iff (reset)
      resend_load |-> all_bcd(resend_begin)
   ) else $error("bcd_seq_counter: resend start number is not BCD");

endmodule

/* rtl/seq_num_fifo.sv */
`timescale 1ns/10ps

module seq_num_fifo #(
   parameter int WIDTH = 24,
   parameter int DEPTH_BITS = 6
) (
   input  logic clk,
   input  logic reset,

   input  logic wr_en,
   input  logic [WIDTH-1:0] din,

   input  logic rd_en,
   output logic [WIDTH-1:0] dout,
   output logic empty
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0] mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0] count;

   logic full;
   logic wr_ok;
   logic rd_ok;

   assign empty = (count == '0);
   assign full = (count == DEPTH);

   // overflow drops the new entry, underflow is a no-op
   assign wr_ok = wr_en && !full;
   assign rd_ok = rd_en && !empty;

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end
      else begin
         case ({wr_ok, rd_ok})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

   // fall-through: head is visible before the read strobe
   assign dout = mem[rd_ptr];

   // the stream can't be stalled, so a full fifo loses a sequence number
   a_no_overflow: assert property (
      @(posedge clk) disable iff (reset)
      !(wr_en && full)
   ) else $error("seq_num_fifo: write while full, sequence number lost");

endmodule

/* rtl/fix_seq_top.sv */
`timescale 1ns/10ps

module fix_seq_top #(
   parameter int TUSER_WIDTH = 128,
   parameter int NUM_DIGITS = 8,
   parameter int OUT_DIGITS = 6,
   parameter int FIFO_DEPTH_BITS = 6
) (
   input  logic clk,
   input  logic reset,

   // receive stream, no ready
   input  logic tvalid,
   input  logic tlast,
   input  logic [TUSER_WIDTH-1:0] tuser,

   input  logic resend_load,
   input  logic [NUM_DIGITS*fix_seq_pkg::DIGIT_W-1:0] resend_begin,

   // consumer side
   input  logic rd_fix_seq_num,
   output logic fix_seq_num_vld,
   output logic [OUT_DIGITS*fix_seq_pkg::DIGIT_W-1:0] fix_new_seq_num,

   output logic resend_ack
);

   localparam int OUT_W = OUT_DIGITS * fix_seq_pkg::DIGIT_W;

   logic [OUT_W-1:0] seq_digits;
   logic seq_wr;
   logic fifo_empty;

   bcd_seq_counter #(
      .TUSER_WIDTH (TUSER_WIDTH),
      .NUM_DIGITS  (NUM_DIGITS),
      .OUT_DIGITS  (OUT_DIGITS)
   ) u_counter (
      .clk          (clk),
      .reset        (reset),
      .tvalid       (tvalid),
      .tlast        (tlast),
      .tuser        (tuser),
      .resend_load  (resend_load),
      .resend_begin (resend_begin),
      .seq_digits   (seq_digits),
      .seq_wr       (seq_wr),
      .resend_ack   (resend_ack)
   );

   seq_num_fifo #(
      .WIDTH      (OUT_W),
      .DEPTH_BITS (FIFO_DEPTH_BITS)
   ) u_fifo (
      .clk   (clk),
      .reset (reset),
      .wr_en (seq_wr),
      .din   (seq_digits),
      .rd_en (rd_fix_seq_num),
      .dout  (fix_new_seq_num),
      .empty (fifo_empty)
   );

   // head valid whenever something is queued
   assign fix_seq_num_vld = !fifo_empty;

endmodule

/* tests/fix_seq_tb_tasks.svh */
`ifndef FIX_SEQ_TB_TASKS_SVH
`define FIX_SEQ_TB_TASKS_SVH

function automatic logic [31:0] next_rand();
   rand_state = rand_state * 32'd1664525 + 32'd1013904223;
   return rand_state;
endfunction

// decimal +1 over eight digits, all nines wraps to zero
function automatic logic [31:0] bcd_increment(input logic [31:0] value);
   logic [31:0] result;
   logic carry;
   result = value;
   carry = 1'b1;
   for (int d = 0; d < 8; d++) begin
      if (carry) begin
         if (result[d*4 +: 4] == 4'd9) begin
            result[d*4 +: 4] = 4'd0;
         end
         else begin
            result[d*4 +: 4] = result[d*4 +: 4] + 4'd1;
            carry = 1'b0;
         end
      end
   end
   return result;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
   checks++;
   if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic idle_cycles(input int n);
   repeat (n) @(posedge clk);
endtask

// one-beat packet; the other tuser bits carry noise
task automatic send_packet(input logic [3:0] mtype, input logic valid);
   logic [127:0] u;
   u = {next_rand(), next_rand(), next_rand(), next_rand()};
   u[fix_seq_pkg::TYPE_LSB +: fix_seq_pkg::TYPE_W] = mtype;
   @(posedge clk);
   tvalid <= valid;
   tlast <= 1'b1;
   tuser <= u;
   @(posedge clk);
   tvalid <= 1'b0;
   tlast <= 1'b0;
   if (valid) begin
      if (mtype == fix_seq_pkg::FIX_MSG_APP) begin
         model_count = bcd_increment(model_count);
      end
      model_q.push_back(model_count[23:0]);
   end
endtask

task automatic load_resend(input string name, input logic [31:0] value, input logic with_end);
   logic [127:0] u;
   u = '0;
   u[fix_seq_pkg::TYPE_LSB +: fix_seq_pkg::TYPE_W] = fix_seq_pkg::FIX_MSG_APP;
   @(posedge clk);
   resend_load <= 1'b1;
   resend_begin <= value;
   if (with_end) begin
      tvalid <= 1'b1;
      tlast <= 1'b1;
      tuser <= u;
   end
   @(posedge clk);
   resend_load <= 1'b0;
   tvalid <= 1'b0;
   tlast <= 1'b0;
   // load wins over the increment, the end still queues a value
   model_count = value;
   model_ack = 1'b1;
   if (with_end) begin
      model_q.push_back(model_count[23:0]);
   end
   @(negedge clk);
   check_value({name, " ack"}, 1, resend_ack);
endtask

task automatic read_and_check(input string name, input logic [23:0] exp);
   int waited;
   logic [23:0] model_head;
   waited = 0;
   @(negedge clk);
   while (!fix_seq_num_vld && waited < 50) begin
      @(negedge clk);
      waited++;
   end
   if (!fix_seq_num_vld) begin
      errors++;
      $display("%s: fix_seq_num_vld did not go high within 50 cycles", name);
   end
   else if (model_q.size() == 0) begin
      errors++;
      $display("%s: a sequence number is queued but none was expected", name);
   end
   else begin
      model_head = model_q.pop_front();
      check_value(name, model_head, fix_new_seq_num);
      if (exp != NO_EXP) begin
         check_value(name, exp, fix_new_seq_num);
      end
      check_value({name, " ack"}, model_ack, resend_ack);
      @(posedge clk);
      rd_fix_seq_num <= 1'b1;
      @(posedge clk);
      rd_fix_seq_num <= 1'b0;
   end
endtask

`endif

/* tests/fix_seq_tb.sv */
`timescale 1ns/10ps

module fix_seq_tb;

   localparam logic [2:0] OP_PKT = 3'd0;
   localparam logic [2:0] OP_RPKT = 3'd1;
   localparam logic [2:0] OP_NOVALID = 3'd2;
   localparam logic [2:0] OP_LOAD = 3'd3;
   localparam logic [2:0] OP_LOADPKT = 3'd4;
   localparam logic [2:0] OP_READ = 3'd5;
   localparam logic [2:0] OP_EMPTY = 3'd6;

   // read entries with this value are checked against the model only
   localparam logic [23:0] NO_EXP = 24'hffffff;

   logic clk;
   logic reset;
   logic tvalid;
   logic tlast;
   logic [127:0] tuser;
   logic resend_load;
   logic [31:0] resend_begin;
   logic rd_fix_seq_num;
   logic fix_seq_num_vld;
   logic [23:0] fix_new_seq_num;
   logic resend_ack;

   int errors;
   int checks;
   bit table_ready;

   // stimulus table, one entry per index
   string tab_name[$];
   logic [2:0] tab_op[$];
   logic [31:0] tab_val[$];
   logic [23:0] tab_exp[$];

   logic [31:0] rand_state;
   logic [31:0] model_count;
   logic model_ack;
   logic [23:0] model_q[$];

   `include "fix_seq_tb_tasks.svh"

   fix_seq_top DUT (
      .clk             (clk),
      .reset           (reset),
      .tvalid          (tvalid),
      .tlast           (tlast),
      .tuser           (tuser),
      .resend_load     (resend_load),
      .resend_begin    (resend_begin),
      .rd_fix_seq_num  (rd_fix_seq_num),
      .fix_seq_num_vld (fix_seq_num_vld),
      .fix_new_seq_num (fix_new_seq_num),
      .resend_ack      (resend_ack)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic add_entry(input string name, input logic [2:0] op,
                            input logic [31:0] val, input logic [23:0] exp);
      tab_name.push_back(name);
      tab_op.push_back(op);
      tab_val.push_back(val);
      tab_exp.push_back(exp);
   endtask

   task automatic build_table();
      add_entry("first app", OP_PKT, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("first app read", OP_READ, 0, 24'h000001);
      add_entry("session", OP_PKT, fix_seq_pkg::FIX_MSG_SESSION, 24'h0);
      add_entry("session read", OP_READ, 0, 24'h000001);
      add_entry("none type", OP_PKT, fix_seq_pkg::FIX_MSG_NONE, 24'h0);
      add_entry("none type read", OP_READ, 0, 24'h000001);
      add_entry("tlast no tvalid", OP_NOVALID, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("no entry queued", OP_EMPTY, 0, 24'h0);
      // count must not have moved on the beat without tvalid
      add_entry("after no tvalid app", OP_PKT, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("after no tvalid read", OP_READ, 0, 24'h000002);
      add_entry("load 99999", OP_LOAD, 32'h0009_9999, 24'h0);
      add_entry("carry app", OP_PKT, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("carry read", OP_READ, 0, 24'h100000);
      add_entry("load all nines", OP_LOAD, 32'h9999_9999, 24'h0);
      add_entry("wrap app", OP_PKT, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("wrap read", OP_READ, 0, 24'h000000);
      add_entry("load 1234", OP_LOAD, 32'h0000_1234, 24'h0);
      add_entry("resend app", OP_PKT, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("resend read", OP_READ, 0, 24'h001235);
      add_entry("load with end", OP_LOADPKT, 32'h0050_0000, 24'h0);
      add_entry("load with end read", OP_READ, 0, 24'h500000);
      add_entry("after load app", OP_PKT, fix_seq_pkg::FIX_MSG_APP, 24'h0);
      add_entry("after load read", OP_READ, 0, 24'h500001);
      for (int k = 0; k < 10; k++) begin
         add_entry("burst packet", OP_RPKT, 0, 24'h0);
      end
      for (int k = 0; k < 10; k++) begin
         add_entry("burst read", OP_READ, 0, NO_EXP);
      end
      add_entry("drained", OP_EMPTY, 0, 24'h0);
   endtask

   initial begin
      reset = 1'b1;
      tvalid = 1'b0;
      tlast = 1'b0;
      tuser = '0;
      resend_load = 1'b0;
      resend_begin = '0;
      rd_fix_seq_num = 1'b0;
      errors = 0;
      checks = 0;
      rand_state = 32'ha065_68ed;
      model_count = '0;
      model_ack = 1'b0;
      build_table();
      table_ready = 1'b1;

      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("vld after reset", 0, fix_seq_num_vld);
      check_value("ack after reset", 0, resend_ack);

      for (int i = 0; i < tab_op.size(); i++) begin
         idle_cycles((next_rand() >> 16) % 3);
         case (tab_op[i])
            OP_PKT: send_packet(tab_val[i][3:0], 1'b1);
            OP_RPKT: send_packet(4'((next_rand() >> 16) % 3), 1'b1);
            OP_NOVALID: send_packet(tab_val[i][3:0], 1'b0);
            OP_LOAD: load_resend(tab_name[i], tab_val[i], 1'b0);
            OP_LOADPKT: load_resend(tab_name[i], tab_val[i], 1'b1);
            OP_READ: read_and_check(tab_name[i], tab_exp[i]);
            default: begin
               idle_cycles(3);
               @(negedge clk);
               check_value(tab_name[i], 0, fix_seq_num_vld);
            end
         endcase
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end
      else begin
         $display("Test failed");
      end
      $finish;
   end

   // bound on run time, generous per table entry
   initial begin
      wait (table_ready);
      #(tab_op.size() * 40 * 8);
      $display("watchdog expired before the stimulus table finished, errors: %0d", errors);
      $display("Test failed");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+tests
rtl/fix_seq_pkg.sv
rtl/bcd_seq_counter.sv
rtl/seq_num_fifo.sv
rtl/fix_seq_top.sv
tests/fix_seq_tb.sv
